// File: source/game_pkg.sv
`default_nettype none

package game_pkg;

	// ##################################################
	// Matrix geometry
	// ##################################################
	localparam int ROW_W    = 8;
	localparam int NUM_ROWS = 8;

	// One matrix row, bit 7 is the leftmost LED
	typedef logic [ROW_W-1:0] row_t;

	// Row 0 is the player row, row 7 the entry row
	typedef row_t [NUM_ROWS-1:0] frame_t;

	typedef logic [2:0]  row_idx_t;
	typedef logic [1:0]  level_t;

	// Serial word: unused nibble, register address, data byte
	typedef logic [15:0] max_word_t;

	// ##################################################
	// MAX7219 register addresses
	// ##################################################
	localparam logic [3:0] REG_DIGIT0       = 4'h1;
	localparam logic [3:0] REG_DECODE       = 4'h9;
	localparam logic [3:0] REG_INTENSITY    = 4'hA;
	localparam logic [3:0] REG_SCAN_LIMIT   = 4'hB;
	localparam logic [3:0] REG_SHUTDOWN     = 4'hC;
	localparam logic [3:0] REG_DISPLAY_TEST = 4'hF;

	// ##################################################
	// Game constants
	// ##################################################
	// Arrow picture, entry row first
	localparam frame_t IDLE_FRAME = {
		8'b0001_0000,
		8'b0011_1000,
		8'b0111_1100,
		8'b0111_1100,
		8'b0011_1000,
		8'b0001_0000,
		8'b0000_0000,
		8'b0001_0000
	};

	localparam row_t PLAYER_START = 8'b0001_0000;

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	localparam logic [15:0] LFSR_SEED = 16'hACE1;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

	localparam level_t MAX_LEVEL = 2'd3;

endpackage

`default_nettype wire

// File: source/button_debounce.sv
`timescale 1ns/1ps
`default_nettype none

module button_debounce #(
	parameter int DEBOUNCE_CYCLES = 500000
) (
	input  wire  clock_50,
	input  wire  arst_n,
	input  logic button_n,
	output logic pressed
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

	// Two-stage synchroniser, idles high like the pin
	logic [1:0]       sync_q;
	logic             sample;
	logic [CNT_W-1:0] cnt_q;

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= 2'b11;
		end else begin
			sync_q <= {sync_q[0], button_n};
		end
	end

	// Active-low pin, so a low sample means held
	assign sample = ~sync_q[1];

	// Count cycles in which the sample disagrees with the output
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			cnt_q   <= '0;
			pressed <= 1'b0;
		end else if (sample != pressed) begin
			if (cnt_q == CNT_LAST) begin
				// Stable long enough, accept the new level
				pressed <= sample;
				cnt_q   <= '0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end else begin
			// Bounce back, start over
			cnt_q <= '0;
		end
	end

endmodule

`default_nettype wire

// File: source/obstacle_field.sv
`timescale 1ns/1ps
`default_nettype none

module obstacle_field #(
	parameter int STEP_CYCLES = 25000000,
	parameter int LEVEL_STEPS = 16
) (
	input  wire                   clock_50,
	input  wire                   arst_n,
	input  logic                  start,
	input  logic                  left,
	input  logic                  right,
	output logic                  frame_valid,
	output game_pkg::frame_t      frame_data
);

	localparam int TMR_W = $clog2(STEP_CYCLES + 1);
	localparam int STP_W = $clog2(LEVEL_STEPS + 1);
	localparam logic [TMR_W-1:0] STEP_FULL = TMR_W'(STEP_CYCLES);
	localparam logic [STP_W-1:0] STEP_LAST = STP_W'(LEVEL_STEPS - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PLAY,
		ST_OVER
	} state_t;

	state_t state_q;

	// ##################################################
	// Button edges
	// ##################################################
	logic start_q;
	logic left_q;
	logic right_q;
	logic start_rise;
	logic left_rise;
	logic right_rise;
	logic move;

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			start_q <= 1'b0;
			left_q  <= 1'b0;
			right_q <= 1'b0;
		end else begin
			start_q <= start;
			left_q  <= left;
			right_q <= right;
		end
	end

	assign start_rise = start & ~start_q;
	assign left_rise  = left & ~left_q;
	assign right_rise = right & ~right_q;
	assign move       = left_rise | right_rise;

	// ##################################################
	// Random row source
	// ##################################################
	logic [15:0] lfsr_q;

	// Free running, so the row depends on press timing
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			lfsr_q <= game_pkg::LFSR_SEED;
		end else if (lfsr_q[0]) begin
			lfsr_q <= (lfsr_q >> 1) ^ game_pkg::LFSR_TAPS;
		end else begin
			lfsr_q <= lfsr_q >> 1;
		end
	end

	// ##################################################
	// Step timer and play field
	// ##################################################
	logic [TMR_W-1:0] tmr_q;
	logic [TMR_W-1:0] step_period;
	logic [STP_W-1:0] step_cnt_q;
	game_pkg::level_t level_q;
	logic             step_tick;
	logic             collide;
	logic             idle_sent_q;
	logic             emit_q;

	game_pkg::row_t                             player_q;
	game_pkg::row_t                             player_next;
	game_pkg::row_t [game_pkg::NUM_ROWS-1:1]    obst_q;

	// Each level halves the step period
	assign step_period = STEP_FULL >> level_q;
	assign step_tick   = (tmr_q == step_period - 1'b1);
	assign collide     = |(obst_q[1] & player_q);

	// Move one column, stop at the edges
	always_comb begin
		player_next = player_q;
		if (left_rise && !right_rise && !player_q[game_pkg::ROW_W-1]) begin
			player_next = player_q << 1;
		end else if (right_rise && !left_rise && !player_q[0]) begin
			player_next = player_q >> 1;
		end
	end

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state_q     <= ST_IDLE;
			tmr_q       <= '0;
			step_cnt_q  <= '0;
			level_q     <= '0;
			player_q    <= game_pkg::PLAYER_START;
			obst_q      <= '0;
			idle_sent_q <= 1'b0;
			emit_q      <= 1'b0;
		end else begin
			emit_q <= 1'b0;
			case (state_q)
				ST_IDLE, ST_OVER: begin
					// Idle picture goes out once after reset
					if (state_q == ST_IDLE && !idle_sent_q) begin
						idle_sent_q <= 1'b1;
						emit_q      <= 1'b1;
					end
					if (start_rise) begin
						state_q    <= ST_PLAY;
						tmr_q      <= '0;
						step_cnt_q <= '0;
						level_q    <= '0;
						player_q   <= game_pkg::PLAYER_START;
						obst_q     <= '0;
						emit_q     <= 1'b1;
					end
				end
				ST_PLAY: begin
					if (step_tick) begin
						tmr_q <= '0;
						if (collide) begin
							// Frozen, the last frame stays on screen
							state_q <= ST_OVER;
						end else begin
							obst_q[game_pkg::NUM_ROWS-2:1] <= obst_q[game_pkg::NUM_ROWS-1:2];
							obst_q[game_pkg::NUM_ROWS-1]   <= lfsr_q[game_pkg::ROW_W-1:0];
							player_q <= player_next;
							emit_q   <= 1'b1;
							if (step_cnt_q == STEP_LAST) begin
								step_cnt_q <= '0;
								if (level_q != game_pkg::MAX_LEVEL) begin
									level_q <= level_q + 1'b1;
								end
							end else begin
								step_cnt_q <= step_cnt_q + 1'b1;
							end
						end
					end else begin
						tmr_q <= tmr_q + 1'b1;
						if (move) begin
							player_q <= player_next;
							emit_q   <= 1'b1;
						end
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Frame goes out the cycle after the update
	assign frame_valid = emit_q;
	assign frame_data  = (state_q == ST_IDLE) ? game_pkg::IDLE_FRAME : {obst_q, player_q};

endmodule

`default_nettype wire

// File: source/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
	input  wire                 clock_50,
	input  wire                 arst_n,
	input  logic                frame_valid,
	input  game_pkg::frame_t    frame_data,
	input  logic                scan_done,
	input  game_pkg::row_idx_t  digit_idx,
	output game_pkg::row_t      digit_data
);

	// ##################################################
	// Pending and display copies
	// ##################################################
	game_pkg::frame_t pend_q;
	game_pkg::frame_t disp_q;
	logic             pend_valid_q;

	// Newest frame wins
	always_ff @(posedge clock_50) begin
		if (frame_valid) begin
			pend_q <= frame_data;
		end
	end

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			pend_valid_q <= 1'b0;
			disp_q       <= '0;
		end else begin
			// Swap only between refreshes so a scan never tears
			if (scan_done && pend_valid_q) begin
				disp_q <= pend_q;
			end
			// A frame arriving with scan_done waits for the next one
			pend_valid_q <= frame_valid | (pend_valid_q & ~scan_done);
		end
	end

	// ##################################################
	// Read side transpose
	// ##################################################
	// Digit d is column 7-d, row 7 in the MSB
	always_comb begin
		for (int r = 0; r < game_pkg::NUM_ROWS; r++) begin
			digit_data[r] = disp_q[r][game_pkg::ROW_W-1-digit_idx];
		end
	end

endmodule

`default_nettype wire

// File: source/max7219_driver.sv
`timescale 1ns/1ps
`default_nettype none

module max7219_driver #(
	parameter int         CLK_DIV   = 8,
	parameter logic [3:0] INTENSITY = 4'hA
) (
	input  wire                 clock_50,
	input  wire                 arst_n,
	output game_pkg::row_idx_t  digit_idx,
	input  game_pkg::row_t      digit_data,
	output logic                scan_done,
	output logic                max7219_din,
	output logic                max7219_ncs,
	output logic                max7219_clk
);

	localparam int DIV_W = $clog2(2 * CLK_DIV + 1);
	localparam logic [DIV_W-1:0] HALF_LAST = DIV_W'(CLK_DIV - 1);
	localparam logic [DIV_W-1:0] GAP_LAST  = DIV_W'(2 * CLK_DIV - 1);
	localparam logic [2:0]       CFG_LAST  = 3'd4;
	localparam logic [3:0]       BIT_LAST  = 4'd15;

	typedef enum logic {
		PH_GAP,
		PH_SHIFT
	} phase_t;

	// ##################################################
	// Word sequencer
	// ##################################################
	logic               cfg_done_q;
	logic [2:0]         cfg_idx_q;
	game_pkg::row_idx_t digit_q;
	logic [3:0]         digit_addr;
	game_pkg::max_word_t word;

	assign digit_idx  = digit_q;
	assign digit_addr = game_pkg::REG_DIGIT0 + {1'b0, digit_q};

	// Config words first and the digit loop after them
	always_comb begin
		if (!cfg_done_q) begin
			case (cfg_idx_q)
				3'd0:    word = {4'h0, game_pkg::REG_DECODE, 8'h00};
				3'd1:    word = {4'h0, game_pkg::REG_INTENSITY, 4'h0, INTENSITY};
				3'd2:    word = {4'h0, game_pkg::REG_SCAN_LIMIT, 8'h07};
				3'd3:    word = {4'h0, game_pkg::REG_SHUTDOWN, 8'h01};
				default: word = {4'h0, game_pkg::REG_DISPLAY_TEST, 8'h00};
			endcase
		end else begin
			word = {4'h0, digit_addr, digit_data};
		end
	end

	// ##################################################
	// Serialiser
	// ##################################################
	phase_t              phase_q;
	logic [DIV_W-1:0]    div_q;
	logic [3:0]          bit_q;
	game_pkg::max_word_t sh_q;
	logic                din_q;
	logic                ncs_q;
	logic                clk_q;
	logic                scan_done_q;

	// Remaining word bits, loaded at the end of each gap
	always_ff @(posedge clock_50) begin
		if (phase_q == PH_GAP && div_q == GAP_LAST) begin
			sh_q <= {word[14:0], 1'b0};
		end else if (phase_q == PH_SHIFT && div_q == HALF_LAST && clk_q
				&& bit_q != BIT_LAST) begin
			sh_q <= sh_q << 1;
		end
	end

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			phase_q     <= PH_GAP;
			div_q       <= '0;
			bit_q       <= '0;
			din_q       <= 1'b0;
			ncs_q       <= 1'b1;
			clk_q       <= 1'b0;
			cfg_done_q  <= 1'b0;
			cfg_idx_q   <= '0;
			digit_q     <= '0;
			scan_done_q <= 1'b0;
		end else begin
			scan_done_q <= 1'b0;
			case (phase_q)
				PH_GAP: begin
					// ncs high for two half periods between words
					if (div_q == GAP_LAST) begin
						div_q   <= '0;
						bit_q   <= '0;
						ncs_q   <= 1'b0;
						din_q   <= word[15];
						phase_q <= PH_SHIFT;
					end else begin
						div_q <= div_q + 1'b1;
					end
				end
				PH_SHIFT: begin
					if (div_q != HALF_LAST) begin
						div_q <= div_q + 1'b1;
					end else if (!clk_q) begin
						// Rising edge where the chip samples din
						div_q <= '0;
						clk_q <= 1'b1;
					end else begin
						div_q <= '0;
						clk_q <= 1'b0;
						if (bit_q == BIT_LAST) begin
							// Word latched on the ncs rise
							ncs_q   <= 1'b1;
							din_q   <= 1'b0;
							phase_q <= PH_GAP;
							if (!cfg_done_q) begin
								if (cfg_idx_q == CFG_LAST) begin
									cfg_done_q <= 1'b1;
								end else begin
									cfg_idx_q <= cfg_idx_q + 1'b1;
								end
							end else begin
								// Refresh ends after digit 7
								if (digit_q == 3'd7) begin
									scan_done_q <= 1'b1;
								end
								digit_q <= digit_q + 1'b1;
							end
						end else begin
							// Next bit while the clock is low
							din_q <= sh_q[15];
							bit_q <= bit_q + 1'b1;
						end
					end
				end
				default: begin
					phase_q <= PH_GAP;
				end
			endcase
		end
	end

	assign scan_done   = scan_done_q;
	assign max7219_din = din_q;
	assign max7219_ncs = ncs_q;
	assign max7219_clk = clk_q;

endmodule

`default_nettype wire

// File: source/dodge_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module dodge_game_top #(
	parameter int         DEBOUNCE_CYCLES = 500000,
	parameter int         STEP_CYCLES     = 25000000,
	parameter int         LEVEL_STEPS     = 16,
	parameter int         CLK_DIV         = 8,
	parameter logic [3:0] INTENSITY       = 4'hA
) (
	input  wire  clock_50,
	input  wire  arst_n,
	input  logic start_btn_n,
	input  logic left_btn_n,
	input  logic right_btn_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	logic               start_pressed;
	logic               left_pressed;
	logic               right_pressed;
	logic               frame_valid;
	game_pkg::frame_t   frame_data;
	logic               scan_done;
	game_pkg::row_idx_t digit_idx;
	game_pkg::row_t     digit_data;

	// ##################################################
	// Buttons
	// ##################################################
	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_start_db (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.button_n (start_btn_n),
		.pressed  (start_pressed)
	);

	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_left_db (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.button_n (left_btn_n),
		.pressed  (left_pressed)
	);

	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_right_db (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.button_n (right_btn_n),
		.pressed  (right_pressed)
	);

	// ##################################################
	// Game engine, frame store, display
	// ##################################################
	obstacle_field #(
		.STEP_CYCLES (STEP_CYCLES),
		.LEVEL_STEPS (LEVEL_STEPS)
	) u_field (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.start       (start_pressed),
		.left        (left_pressed),
		.right       (right_pressed),
		.frame_valid (frame_valid),
		.frame_data  (frame_data)
	);

	frame_buffer u_fbuf (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.frame_valid (frame_valid),
		.frame_data  (frame_data),
		.scan_done   (scan_done),
		.digit_idx   (digit_idx),
		.digit_data  (digit_data)
	);

	max7219_driver #(
		.CLK_DIV   (CLK_DIV),
		.INTENSITY (INTENSITY)
	) u_driver (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.digit_idx   (digit_idx),
		.digit_data  (digit_data),
		.scan_done   (scan_done),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

`default_nettype wire

// File: verif/dodge_game_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dodge_game_sva (
	input wire                 clock_50,
	input wire                 arst_n,
	input logic                max7219_ncs,
	input logic                max7219_clk,
	input logic                max7219_din,
	input logic                scan_done,
	input game_pkg::row_idx_t  digit_idx,
	input game_pkg::row_t      digit_data
);

	int fail_cnt = 0;

	logic       sclk_d;
	logic [4:0] edges_q;

	// Rising serial clock edges inside the current word
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			sclk_d  <= 1'b0;
			edges_q <= '0;
		end else begin
			sclk_d <= max7219_clk;
			if (max7219_ncs) begin
				edges_q <= '0;
			end else if (max7219_clk && !sclk_d) begin
				edges_q <= edges_q + 1'b1;
			end
		end
	end

	// ##################################################
	// Serial protocol
	// ##################################################
	a_word_len: assert property (@(posedge clock_50) disable iff (!arst_n)
		$rose(max7219_ncs) |-> edges_q == 5'd16)
		else begin
			fail_cnt++;
			$error("chip select high after %0d serial clock edges", edges_q);
		end

	// Chip samples on the rising edge
	a_din_stable: assert property (@(posedge clock_50) disable iff (!arst_n)
		max7219_clk |-> $stable(max7219_din))
		else begin
			fail_cnt++;
			$error("din moved while the serial clock was high");
		end

	// Refresh ends with the digit 7 word
	a_scan_done: assert property (@(posedge clock_50) disable iff (!arst_n)
		scan_done |-> $rose(max7219_ncs) && $past(digit_idx) == 3'd7)
		else begin
			fail_cnt++;
			$error("scan_done not after a digit 7 word");
		end

	// ##################################################
	// Frame handoff
	// ##################################################
	// Read data moves only with a new digit or right after a swap
	a_disp_swap: assert property (@(posedge clock_50) disable iff (!arst_n)
		!$stable(digit_data) |-> !$stable(digit_idx) || $past(scan_done))
		else begin
			fail_cnt++;
			$error("display copy changed outside a scan_done cycle");
		end

endmodule

bind max7219_driver dodge_game_sva u_sva (
	.clock_50    (clock_50),
	.arst_n      (arst_n),
	.max7219_ncs (max7219_ncs),
	.max7219_clk (max7219_clk),
	.max7219_din (max7219_din),
	.scan_done   (scan_done),
	.digit_idx   (digit_idx),
	.digit_data  (digit_data)
);

`default_nettype wire

// File: verif/dodge_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dodge_game_tb;

	localparam int         DEBOUNCE_CYCLES = 4;
	// Level 3 step of 2000 cycles spans over two refreshes of 544 cycles
	localparam int         STEP_CYCLES     = 16000;
	localparam int         LEVEL_STEPS     = 2;
	localparam int         CLK_DIV         = 2;
	localparam logic [3:0] INTENSITY       = 4'h5;

	// Wait limits in clock cycles
	localparam int FRAME_LIMIT = 2000;
	localparam int STEP_LIMIT  = 2 * STEP_CYCLES;
	localparam int CFG_LIMIT   = 2000;

	localparam int MOVES     = 6;
	localparam int ROUNDS    = 3;
	localparam int MAX_STEPS = 40;

	// Button pin index
	localparam int BTN_START = 0;
	localparam int BTN_LEFT  = 1;
	localparam int BTN_RIGHT = 2;

	logic       clock_50;
	logic       arst_n;
	logic [2:0] btn_n;
	logic       max7219_din;
	logic       max7219_ncs;
	logic       max7219_clk;

	logic [31:0] rng;
	int          err_cnt = 0;
	int          chk_cnt = 0;
	int          sva_fails;

	// Model of the game
	game_pkg::row_t   model_player;
	game_pkg::frame_t prev_frame;

	// Serial decoder state
	logic                sclk_d;
	int                  bit_cnt;
	game_pkg::max_word_t shift_word;
	int                  cfg_cnt;
	game_pkg::max_word_t cfg_words [5];
	int                  digit_cnt;
	game_pkg::frame_t    cur_frame;
	game_pkg::frame_t    last_frame;
	int                  frame_cnt;

	dodge_game_top #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.STEP_CYCLES     (STEP_CYCLES),
		.LEVEL_STEPS     (LEVEL_STEPS),
		.CLK_DIV         (CLK_DIV),
		.INTENSITY       (INTENSITY)
	) DUT (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.start_btn_n (btn_n[BTN_START]),
		.left_btn_n  (btn_n[BTN_LEFT]),
		.right_btn_n (btn_n[BTN_RIGHT]),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

	initial begin
		clock_50 = 1'b0;
		forever #5 clock_50 = ~clock_50;
	end

	// ##################################################
	// Helpers
	// ##################################################
	task automatic check(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		chk_cnt++;
		if (actual !== expected) begin
			err_cnt++;
			$display("[ERROR] %0t ns %s: got %0h, expected %0h",
				$time, name, actual, expected);
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Random value below n
	function automatic int unsigned roll(input int unsigned n);
		rng = xorshift32(rng);
		return rng % n;
	endfunction

	task automatic stop_on_timeout(input string what);
		$display("[%0t] timed out waiting for %s", $time, what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	// Optional short bounce before a real press and release
	task automatic press(input int idx);
		int hold;
		int gap;
		if (roll(2) == 1) begin
			@(posedge clock_50);
			btn_n[idx] <= 1'b0;
			repeat (1 + roll(2)) @(posedge clock_50);
			btn_n[idx] <= 1'b1;
			repeat (4) @(posedge clock_50);
		end
		@(posedge clock_50);
		btn_n[idx] <= 1'b0;
		hold = 8 + roll(16);
		repeat (hold) @(posedge clock_50);
		btn_n[idx] <= 1'b1;
		gap = 8 + roll(16);
		repeat (gap) @(posedge clock_50);
	endtask

	task automatic wait_frames(input int n);
		int target;
		int cycles;
		target = frame_cnt + n;
		cycles = 0;
		while (frame_cnt < target) begin
			@(posedge clock_50);
			cycles++;
			if (cycles > n * FRAME_LIMIT) begin
				stop_on_timeout("a refresh of the display");
			end
		end
	endtask

	task automatic wait_frame_change(input game_pkg::frame_t ref_frame);
		int cycles;
		cycles = 0;
		while (last_frame == ref_frame) begin
			@(posedge clock_50);
			cycles++;
			if (cycles > STEP_LIMIT) begin
				stop_on_timeout("the next obstacle step");
			end
		end
	endtask

	task automatic wait_config;
		int cycles;
		cycles = 0;
		while (cfg_cnt < 5) begin
			@(posedge clock_50);
			cycles++;
			if (cycles > CFG_LIMIT) begin
				stop_on_timeout("the configuration words");
			end
		end
	endtask

	// ##################################################
	// Serial decoder
	// ##################################################
	// Config words first and digit words rebuilt into frames after them
	task automatic take_word(input game_pkg::max_word_t w);
		logic [3:0] addr;
		addr = game_pkg::REG_DIGIT0 + 4'(digit_cnt);
		if (cfg_cnt < 5) begin
			cfg_words[cfg_cnt] = w;
			cfg_cnt++;
		end else begin
			check("digit word address", w[15:8], {4'h0, addr});
			// Digit d bit r is row r column 7-d
			for (int r = 0; r < game_pkg::NUM_ROWS; r++) begin
				cur_frame[r][game_pkg::ROW_W-1-digit_cnt] = w[r];
			end
			if (digit_cnt == 7) begin
				last_frame = cur_frame;
				frame_cnt++;
				digit_cnt = 0;
			end else begin
				digit_cnt++;
			end
		end
	endtask

	// Outputs move on the rising edge and are sampled on the falling one
	always @(negedge clock_50) begin
		if (!arst_n) begin
			sclk_d     = 1'b0;
			bit_cnt    = 0;
			shift_word = '0;
			cfg_cnt    = 0;
			digit_cnt  = 0;
			cur_frame  = '0;
			last_frame = '0;
			frame_cnt  = 0;
		end else begin
			if (!max7219_ncs && max7219_clk && !sclk_d) begin
				shift_word = {shift_word[14:0], max7219_din};
				bit_cnt++;
				if (bit_cnt == 16) begin
					bit_cnt = 0;
					take_word(shift_word);
				end
			end
			if (max7219_ncs && bit_cnt != 0) begin
				err_cnt++;
				$display("[%0t] chip select rose after only %0d bits", $time, bit_cnt);
				bit_cnt = 0;
			end
			sclk_d = max7219_clk;
		end
	end

	// ##################################################
	// Game phases
	// ##################################################
	task automatic start_game;
		game_pkg::frame_t exp_frame;
		press(BTN_START);
		model_player = game_pkg::PLAYER_START;
		exp_frame    = '0;
		exp_frame[0] = game_pkg::PLAYER_START;
		wait_frames(3);
		check("start frame", last_frame, exp_frame);
		prev_frame = last_frame;
	endtask

	// All moves fit inside the first level 0 step
	task automatic move_test;
		int dir;
		for (int i = 0; i < MOVES; i++) begin
			dir = roll(2);
			if (dir == 1) begin
				press(BTN_LEFT);
				if (!model_player[game_pkg::ROW_W-1]) begin
					model_player = model_player << 1;
				end
			end else begin
				press(BTN_RIGHT);
				if (!model_player[0]) begin
					model_player = model_player >> 1;
				end
			end
			wait_frames(3);
			check("player row", last_frame[0], model_player);
			check("obstacle rows after move", last_frame[7:1], prev_frame[7:1]);
			prev_frame = last_frame;
		end
	endtask

	task automatic shift_test;
		int  steps;
		logic hit;
		steps = 0;
		hit   = 1'b0;
		while (!hit && steps < MAX_STEPS) begin
			wait_frame_change(prev_frame);
			check("player row in play", last_frame[0], model_player);
			check("shifted rows", last_frame[6:1], prev_frame[7:2]);
			prev_frame = last_frame;
			steps++;
			// Overlap now means the next step ends the game
			hit = |(prev_frame[1] & prev_frame[0]);
		end
		if (!hit) begin
			err_cnt++;
			$display("[%0t] no collision after %0d steps", $time, steps);
		end
	endtask

	// Collision comes at level 3 where four refreshes outlast one step
	task automatic collision_test;
		game_pkg::frame_t frozen;
		frozen = prev_frame;
		// Colliding step goes by before any press
		for (int k = 0; k < 4; k++) begin
			wait_frames(1);
			check("frozen frame", last_frame, frozen);
		end
		for (int i = 0; i < 4; i++) begin
			if (roll(2) == 1) begin
				press(BTN_LEFT);
			end else begin
				press(BTN_RIGHT);
			end
			for (int k = 0; k < 4; k++) begin
				wait_frames(1);
				check("frozen frame", last_frame, frozen);
			end
		end
	endtask

	// ##################################################
	// Main sequence
	// ##################################################
	initial begin
		btn_n  = 3'b111;
		arst_n = 1'b0;
		rng    = 32'hba8;
		model_player = game_pkg::PLAYER_START;
		prev_frame   = '0;

		repeat (8) @(posedge clock_50);
		check("max7219_ncs in reset", max7219_ncs, 1'b1);
		check("max7219_clk in reset", max7219_clk, 1'b0);
		check("max7219_din in reset", max7219_din, 1'b0);
		arst_n <= 1'b1;

		// Five setup words in fixed order
		wait_config();
		check("decode word", cfg_words[0], {4'h0, game_pkg::REG_DECODE, 8'h00});
		check("intensity word", cfg_words[1],
			{4'h0, game_pkg::REG_INTENSITY, 4'h0, INTENSITY});
		check("scan limit word", cfg_words[2], {4'h0, game_pkg::REG_SCAN_LIMIT, 8'h07});
		check("shutdown word", cfg_words[3], {4'h0, game_pkg::REG_SHUTDOWN, 8'h01});
		check("display test word", cfg_words[4],
			{4'h0, game_pkg::REG_DISPLAY_TEST, 8'h00});
		$display("[%0t] reset and configuration test finished, errors %0d", $time, err_cnt);

		// Display copy starts blank and shows the arrow after the first swap
		wait_frames(1);
		check("blank first frame", last_frame, 64'h0);
		for (int i = 0; i < 3; i++) begin
			wait_frames(1);
			check("idle frame", last_frame, game_pkg::IDLE_FRAME);
		end
		$display("[%0t] idle picture test finished, errors %0d", $time, err_cnt);

		for (int round = 0; round < ROUNDS; round++) begin
			start_game();
			move_test();
			$display("[%0t] round %0d movement test finished, errors %0d",
				$time, round, err_cnt);
			shift_test();
			$display("[%0t] round %0d obstacle shift test finished, errors %0d",
				$time, round, err_cnt);
			collision_test();
			$display("[%0t] round %0d collision test finished, errors %0d",
				$time, round, err_cnt);
		end

		// Restart after the last collision
		start_game();
		$display("[%0t] restart test finished, errors %0d", $time, err_cnt);

		sva_fails = DUT.u_driver.u_sva.fail_cnt;
		$display("checks %0d, errors %0d, assertion failures %0d",
			chk_cnt, err_cnt, sva_fails);
		if (err_cnt == 0 && sva_fails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
source/game_pkg.sv
source/button_debounce.sv
source/obstacle_field.sv
source/frame_buffer.sv
source/max7219_driver.sv
source/dodge_game_top.sv
verif/dodge_game_sva.sv
verif/dodge_game_tb.sv
